// File: verilog/fb_split_cfg.svh
//////////////////////////////
// Framebuffer geometry and external memory layout.
// Column field sits in the low address bits and the line field above it.
// Columns at or above FB_LOCAL_COLS live in external memory.
//////////////////////////////
`ifndef FB_SPLIT_CFG_SVH
`define FB_SPLIT_CFG_SVH

// Framebuffer address fields
`define FB_COL_W 9
`define FB_LINE_W 8

// First column that is not held on chip
`define FB_LOCAL_COLS 352

// External memory word address
`define FB_EXT_ADDR_W 24

// Region prefixes of the two buffers in external memory
`define FB0_EXT_BASE 6'b001010
`define FB1_EXT_BASE 6'b001100

`endif

// File: verilog/fb_split_pkg.sv
//////////////////////////////
// Types shared by the split framebuffer.
// Widths follow fb_split_cfg.svh.
//////////////////////////////
`default_nettype none

`include "fb_split_cfg.svh"

package fb_split_pkg;

	// One 16-bit pixel
	typedef logic [15:0] pix_t;

	// Byte write enable, bit 1 is the high byte
	typedef logic [1:0] be_t;

	// Line in the upper bits, column in the lower bits
	typedef logic [`FB_LINE_W+`FB_COL_W-1:0] fb_addr_t;

	// Word address on the external memory port
	typedef logic [`FB_EXT_ADDR_W-1:0] ext_addr_t;

	//////////////////////////////
	// External port arbiter
	//////////////////////////////

	// Idle, or waiting on a read for buffer 0 or buffer 1
	typedef enum logic [1:0] {
		arb_idle,
		arb_rd0,
		arb_rd1
	} arb_state_t;

endpackage

`default_nettype wire

// File: verilog/fb_local_ram.sv
//////////////////////////////
// On-chip part of one framebuffer.
// Address is {column, line}, registered read, one cycle latency.
// Only columns below FB_LOCAL_COLS may be written.
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "fb_split_cfg.svh"

module fb_local_ram (
	input  wire                               clk_sys,
	input  wire fb_split_pkg::be_t            we,
	input  wire [`FB_COL_W+`FB_LINE_W-1:0]    addr,
	input  wire fb_split_pkg::pix_t           d,
	output fb_split_pkg::pix_t                q
);
	import fb_split_pkg::*;

	localparam int ADDR_W = `FB_COL_W + `FB_LINE_W;
	localparam int DEPTH  = `FB_LOCAL_COLS << `FB_LINE_W;

	// Column-major storage, 256 lines per column
	pix_t mem [0:DEPTH-1];

	logic [`FB_COL_W-1:0] wr_col;

	assign wr_col = addr[ADDR_W-1 -: `FB_COL_W];

	// Per-byte write
	always_ff @(posedge clk_sys) begin
		if (we[0]) begin
			mem[addr][7:0] <= d[7:0];
		end
		if (we[1]) begin
			mem[addr][15:8] <= d[15:8];
		end
	end

	// Registered read port
	always_ff @(posedge clk_sys) begin
		q <= mem[addr];
	end

	// The bank must steer external columns away from this RAM
	a_local_col_range: assert property (
		@(posedge clk_sys) (|we) |-> (wr_col < `FB_LOCAL_COLS)
	) else $error("local framebuffer write to external column %0d", wr_col);

endmodule

`default_nettype wire

// File: verilog/fb_bank.sv
//////////////////////////////
// Split logic of one framebuffer.
// Strobes must stay stable until the bank is no longer busy.
// A request is captured on the rising edge of rd or of any we bit.
// External read data is held in a return register until the next read.
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "fb_split_cfg.svh"

module fb_bank (
	input  wire                        clk_sys,
	input  wire                        rst_sys,
	input  wire fb_split_pkg::fb_addr_t addr,
	input  wire fb_split_pkg::pix_t    d,
	input  wire fb_split_pkg::be_t     we,
	input  wire                        rd,
	output fb_split_pkg::pix_t         q,
	output logic                       ext_sel,
	output logic                       ext_rd_req,
	output fb_split_pkg::be_t          ext_wr_req,
	output logic                       busy,
	input  wire                        rd_done,
	input  wire                        wr_done,
	input  wire fb_split_pkg::pix_t    ext_q
);
	import fb_split_pkg::*;

	logic [`FB_COL_W-1:0]            col;
	logic [`FB_LINE_W-1:0]           line;
	logic [`FB_COL_W+`FB_LINE_W-1:0] ram_addr;
	be_t                             ram_we;
	pix_t                            ram_q;

	logic rd_old;
	logic we_old;
	logic rd_rise;
	logic we_rise;
	logic start;

	logic rd_pend;
	be_t  wr_pend;
	pix_t ext_ret;

	//////////////////////////////
	// Address split
	//////////////////////////////
	assign col  = addr[`FB_COL_W-1:0];
	assign line = addr[`FB_COL_W +: `FB_LINE_W];

	assign ext_sel  = (col >= `FB_LOCAL_COLS);
	assign ram_addr = {col, line};
	assign ram_we   = we & {2{~ext_sel}};

	fb_local_ram fb_local_ram_i (
		.clk_sys (clk_sys),
		.we      (ram_we),
		.addr    (ram_addr),
		.d       (d),
		.q       (ram_q)
	);

	//////////////////////////////
	// External request capture
	//////////////////////////////
	assign rd_rise = rd & ~rd_old;
	assign we_rise = (|we) & ~we_old;
	assign start   = (rd_rise | we_rise) & ext_sel;

	always_ff @(posedge clk_sys) begin
		if (rst_sys) begin
			rd_old  <= 1'b0;
			we_old  <= 1'b0;
			rd_pend <= 1'b0;
			wr_pend <= '0;
			busy    <= 1'b0;
		end else begin
			rd_old <= rd;
			we_old <= |we;

			// Stay busy while the other half of a combined request is pending
			if (rd_done) begin
				rd_pend <= 1'b0;
				busy    <= |wr_pend;
			end
			if (wr_done) begin
				wr_pend <= '0;
				busy    <= rd_pend;
			end

			if (start) begin
				rd_pend <= rd_rise;
				wr_pend <= we_rise ? we : '0;
				busy    <= 1'b1;
			end
		end
	end

	assign ext_rd_req = rd_pend;
	assign ext_wr_req = wr_pend;

	// Returned external word
	always_ff @(posedge clk_sys) begin
		if (rd_done) begin
			ext_ret <= ext_q;
		end
	end

	assign q = ext_sel ? ext_ret : ram_q;

	// A read completion must belong to a request this bank made
	a_rd_done_busy: assert property (
		@(posedge clk_sys) disable iff (rst_sys) rd_done |-> busy
	) else $error("rd_done while bank idle");

endmodule

`default_nettype wire

// File: verilog/fb_ext_arbiter.sv
//////////////////////////////
// Orders both banks' requests onto one external port.
// Fixed priority FB0 read, FB0 write, FB1 read, FB1 write.
// One read in flight at a time, read data taken when busy drops.
// Address and data are read from the sprite side, which holds them.
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "fb_split_cfg.svh"

module fb_ext_arbiter (
	input  wire                         clk_sys,
	input  wire                         rst_sys,
	input  wire fb_split_pkg::fb_addr_t fb0_addr,
	input  wire fb_split_pkg::fb_addr_t fb1_addr,
	input  wire fb_split_pkg::pix_t     fb0_d,
	input  wire fb_split_pkg::pix_t     fb1_d,
	input  wire                         fb0_ext_rd_req,
	input  wire                         fb1_ext_rd_req,
	input  wire fb_split_pkg::be_t      fb0_ext_wr_req,
	input  wire fb_split_pkg::be_t      fb1_ext_wr_req,
	output logic                        fb0_rd_done,
	output logic                        fb1_rd_done,
	output logic                        fb0_wr_done,
	output logic                        fb1_wr_done,
	input  wire                         ext_busy,
	output fb_split_pkg::ext_addr_t     ext_addr,
	output fb_split_pkg::pix_t          ext_d,
	output fb_split_pkg::be_t           ext_we,
	output logic                        ext_rd
);
	import fb_split_pkg::*;

	localparam int BASE_W = `FB_EXT_ADDR_W - 1 - `FB_COL_W - `FB_LINE_W;

	arb_state_t state;

	logic issue;
	logic gnt_rd0;
	logic gnt_wr0;
	logic gnt_rd1;
	logic gnt_wr1;
	logic rd_fin;

	// Region prefix, a zero bit, then column and line
	function automatic ext_addr_t ext_word(input logic [BASE_W-1:0] base, input fb_addr_t a);
		ext_word = {base, 1'b0, a[`FB_COL_W-1:0], a[`FB_COL_W +: `FB_LINE_W]};
	endfunction

	//////////////////////////////
	// Grant
	//////////////////////////////

	// Port is free once busy is low and no write pulse is still on it
	assign issue = (state == arb_idle) && !ext_busy && (ext_we == '0);

	always_comb begin
		gnt_rd0 = 1'b0;
		gnt_wr0 = 1'b0;
		gnt_rd1 = 1'b0;
		gnt_wr1 = 1'b0;
		if (issue) begin
			if (fb0_ext_rd_req) begin
				gnt_rd0 = 1'b1;
			end else if (|fb0_ext_wr_req) begin
				gnt_wr0 = 1'b1;
			end else if (fb1_ext_rd_req) begin
				gnt_rd1 = 1'b1;
			end else if (|fb1_ext_wr_req) begin
				gnt_wr1 = 1'b1;
			end
		end
	end

	// First cycle with busy low after the read pulse has gone
	assign rd_fin = !ext_busy && !ext_rd;

	assign fb0_rd_done = (state == arb_rd0) && rd_fin;
	assign fb1_rd_done = (state == arb_rd1) && rd_fin;
	assign fb0_wr_done = gnt_wr0;
	assign fb1_wr_done = gnt_wr1;

	//////////////////////////////
	// Control FSM
	//////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (rst_sys) begin
			state  <= arb_idle;
			ext_rd <= 1'b0;
			ext_we <= '0;
		end else begin
			ext_rd <= 1'b0;
			ext_we <= '0;
			case (state)
				arb_idle: begin
					if (gnt_rd0) begin
						ext_rd <= 1'b1;
						state  <= arb_rd0;
					end else if (gnt_rd1) begin
						ext_rd <= 1'b1;
						state  <= arb_rd1;
					end else if (gnt_wr0) begin
						ext_we <= fb0_ext_wr_req;
					end else if (gnt_wr1) begin
						ext_we <= fb1_ext_wr_req;
					end
				end
				arb_rd0, arb_rd1: begin
					if (rd_fin) begin
						state <= arb_idle;
					end
				end
				default: state <= arb_idle;
			endcase
		end
	end

	// Port address and write data
	always_ff @(posedge clk_sys) begin
		if (gnt_rd0 || gnt_wr0) begin
			ext_addr <= ext_word(`FB0_EXT_BASE, fb0_addr);
		end else if (gnt_rd1 || gnt_wr1) begin
			ext_addr <= ext_word(`FB1_EXT_BASE, fb1_addr);
		end
		if (gnt_wr0) begin
			ext_d <= fb0_d;
		end else if (gnt_wr1) begin
			ext_d <= fb1_d;
		end
	end

	a_rd_we_excl: assert property (
		@(posedge clk_sys) disable iff (rst_sys) !(ext_rd && (|ext_we))
	) else $error("ext_rd and ext_we high together");

endmodule

`default_nettype wire

// File: verilog/fb_split_top.sv
//////////////////////////////
// Split framebuffer pair for the sprite processor.
// fb_rdy low while either buffer waits on external memory.
// Everything runs on clk_sys.
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module fb_split_top (
	input  wire                         clk_sys,
	input  wire                         rst_sys,

	// Sprite side of buffer 0
	input  wire fb_split_pkg::fb_addr_t fb0_addr,
	input  wire fb_split_pkg::pix_t     fb0_d,
	input  wire fb_split_pkg::be_t      fb0_we,
	input  wire                         fb0_rd,
	output fb_split_pkg::pix_t          fb0_q,

	// Sprite side of buffer 1
	input  wire fb_split_pkg::fb_addr_t fb1_addr,
	input  wire fb_split_pkg::pix_t     fb1_d,
	input  wire fb_split_pkg::be_t      fb1_we,
	input  wire                         fb1_rd,
	output fb_split_pkg::pix_t          fb1_q,

	output logic                        fb_rdy,

	// External memory port
	output fb_split_pkg::ext_addr_t     ext_addr,
	output fb_split_pkg::pix_t          ext_d,
	output fb_split_pkg::be_t           ext_we,
	output logic                        ext_rd,
	input  wire                         ext_busy,
	input  wire fb_split_pkg::pix_t     ext_q
);
	import fb_split_pkg::*;

	logic fb0_ext_sel;
	logic fb1_ext_sel;
	logic fb0_ext_rd_req;
	logic fb1_ext_rd_req;
	be_t  fb0_ext_wr_req;
	be_t  fb1_ext_wr_req;
	logic fb0_busy;
	logic fb1_busy;
	logic fb0_rd_done;
	logic fb1_rd_done;
	logic fb0_wr_done;
	logic fb1_wr_done;

	fb_bank fb_bank0_i (
		.clk_sys    (clk_sys),
		.rst_sys    (rst_sys),
		.addr       (fb0_addr),
		.d          (fb0_d),
		.we         (fb0_we),
		.rd         (fb0_rd),
		.q          (fb0_q),
		.ext_sel    (fb0_ext_sel),
		.ext_rd_req (fb0_ext_rd_req),
		.ext_wr_req (fb0_ext_wr_req),
		.busy       (fb0_busy),
		.rd_done    (fb0_rd_done),
		.wr_done    (fb0_wr_done),
		.ext_q      (ext_q)
	);

	fb_bank fb_bank1_i (
		.clk_sys    (clk_sys),
		.rst_sys    (rst_sys),
		.addr       (fb1_addr),
		.d          (fb1_d),
		.we         (fb1_we),
		.rd         (fb1_rd),
		.q          (fb1_q),
		.ext_sel    (fb1_ext_sel),
		.ext_rd_req (fb1_ext_rd_req),
		.ext_wr_req (fb1_ext_wr_req),
		.busy       (fb1_busy),
		.rd_done    (fb1_rd_done),
		.wr_done    (fb1_wr_done),
		.ext_q      (ext_q)
	);

	fb_ext_arbiter fb_ext_arbiter_i (
		.clk_sys        (clk_sys),
		.rst_sys        (rst_sys),
		.fb0_addr       (fb0_addr),
		.fb1_addr       (fb1_addr),
		.fb0_d          (fb0_d),
		.fb1_d          (fb1_d),
		.fb0_ext_rd_req (fb0_ext_rd_req),
		.fb1_ext_rd_req (fb1_ext_rd_req),
		.fb0_ext_wr_req (fb0_ext_wr_req),
		.fb1_ext_wr_req (fb1_ext_wr_req),
		.fb0_rd_done    (fb0_rd_done),
		.fb1_rd_done    (fb1_rd_done),
		.fb0_wr_done    (fb0_wr_done),
		.fb1_wr_done    (fb1_wr_done),
		.ext_busy       (ext_busy),
		.ext_addr       (ext_addr),
		.ext_d          (ext_d),
		.ext_we         (ext_we),
		.ext_rd         (ext_rd)
	);

	assign fb_rdy = ~(fb0_busy | fb1_busy);

	// A busy bank must be addressing its external region
	a_busy_ext_sel: assert property (
		@(posedge clk_sys) disable iff (rst_sys)
		(fb0_busy |-> fb0_ext_sel) and (fb1_busy |-> fb1_ext_sel)
	) else $error("busy bank address left its external region");

endmodule

`default_nettype wire

// File: dv/fb_split_checker.sv
//////////////////////////////
// Reference model of both framebuffers.
// Samples on the rising edge and assumes that the sprite side holds
// address and data until fb_rdy returns.
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

`include "fb_split_cfg.svh"

module fb_split_checker (
	input  wire                         clk_sys,
	input  wire                         rst_sys,
	input  wire fb_split_pkg::fb_addr_t fb0_addr,
	input  wire fb_split_pkg::pix_t     fb0_d,
	input  wire fb_split_pkg::be_t      fb0_we,
	input  wire                         fb0_rd,
	input  wire fb_split_pkg::pix_t     fb0_q,
	input  wire fb_split_pkg::fb_addr_t fb1_addr,
	input  wire fb_split_pkg::pix_t     fb1_d,
	input  wire fb_split_pkg::be_t      fb1_we,
	input  wire                         fb1_rd,
	input  wire fb_split_pkg::pix_t     fb1_q,
	input  wire                         fb_rdy,
	input  wire fb_split_pkg::ext_addr_t ext_addr,
	input  wire fb_split_pkg::pix_t     ext_d,
	input  wire fb_split_pkg::be_t      ext_we,
	input  wire                         ext_rd,
	input  wire                         row_end,
	input  wire [31:0]                  row_idx,
	output int                          err_cnt,
	output int                          chk_cnt
);
	import fb_split_pkg::*;

	// Reference pixels keyed by bank and word address
	pix_t      ref_mem [int];
	fb_addr_t  a [2];
	pix_t      d [2];
	be_t       we [2];
	logic      rd [2];
	pix_t      q [2];
	// Write request as the sprite side presented it
	be_t       wr_be [2];
	pix_t      wr_d [2];
	logic [1:0] rd_prev;
	logic [1:0] we_prev;
	logic [1:0] rd_pend;
	logic [1:0] outst;
	logic [1:0] served;
	logic      start_prev;
	logic      start_now;
	logic      rdy_prev;
	logic      rst_seen;
	int        row_err_base;
	int        key;
	int        n;
	ext_addr_t exp_addr;

	initial begin
		err_cnt = 0;
		chk_cnt = 0;
		row_err_base = 0;
	end

	task automatic check(input logic ok, input string msg);
		chk_cnt++;
		if (!ok) begin
			err_cnt++;
			$display("error at %0t: %s", $time, msg);
		end
	endtask

	always @(posedge clk_sys) begin
		a[0] = fb0_addr;
		a[1] = fb1_addr;
		d[0] = fb0_d;
		d[1] = fb1_d;
		we[0] = fb0_we;
		we[1] = fb1_we;
		rd[0] = fb0_rd;
		rd[1] = fb1_rd;
		q[0] = fb0_q;
		q[1] = fb1_q;
		if (rst_sys) begin
			rst_seen = 1'b1;
			{rd_prev, we_prev, rd_pend, outst, served} = '0;
			start_prev = 1'b0;
			rdy_prev = 1'b1;
		end else begin
			if (rst_seen) begin
				rst_seen = 1'b0;
				check(fb_rdy && !ext_rd && ext_we == '0, "port not idle after reset");
			end

			////////////////////////////// External port accesses
			if (ext_rd || (|ext_we)) begin
				n = (ext_addr[23:18] == `FB1_EXT_BASE) ? 1 : 0;
				check(ext_addr[23:18] == `FB0_EXT_BASE || ext_addr[23:18] == `FB1_EXT_BASE,
					$sformatf("ext_addr %h has no buffer base", ext_addr));
				exp_addr = {(n ? `FB1_EXT_BASE : `FB0_EXT_BASE), 1'b0,
					a[n][`FB_COL_W-1:0], a[n][`FB_COL_W +: `FB_LINE_W]};
				check(ext_addr == exp_addr,
					$sformatf("ext_addr %h, expected %h", ext_addr, exp_addr));
				check(outst[n], $sformatf("port access for idle buffer %0d", n));
				check(!(n == 1 && outst[0] && !served[0]), "buffer 1 served before buffer 0");
				if (|ext_we) begin
					check(ext_we == wr_be[n] && ext_d == wr_d[n],
						$sformatf("ext write %h/%b, expected %h/%b",
							ext_d, ext_we, wr_d[n], wr_be[n]));
				end
				served[n] = 1'b1;
			end

			// Ready level only drops for an external request
			check(!(start_prev && fb_rdy), "fb_rdy high during an external access");
			check(!(rdy_prev && !fb_rdy && !start_prev), "fb_rdy fell on an on-chip access");

			for (int i = 0; i < 2; i++) begin
				if (rd_pend[i] && fb_rdy) begin
					key = (i << 17) | int'(a[i]);
					if (!ref_mem.exists(key)) begin
						check(1'b0, $sformatf("read of unwritten word %h", a[i]));
					end else begin
						check(q[i] == ref_mem[key], $sformatf("fb%0d_q %h at %h, expected %h",
							i, q[i], a[i], ref_mem[key]));
					end
					rd_pend[i] = 1'b0;
				end
			end
			if (fb_rdy && !start_prev) begin
				outst = '0;
			end

			////////////////////////////// New requests
			start_now = 1'b0;
			for (int i = 0; i < 2; i++) begin
				key = (i << 17) | int'(a[i]);
				if ((rd[i] && !rd_prev[i]) || ((|we[i]) && !we_prev[i])) begin
					if (a[i][`FB_COL_W-1:0] >= `FB_LOCAL_COLS) begin
						start_now = 1'b1;
						outst[i] = 1'b1;
						served[i] = 1'b0;
					end
				end
				if (rd[i] && !rd_prev[i]) begin
					rd_pend[i] = 1'b1;
				end
				if ((|we[i]) && !we_prev[i]) begin
					wr_be[i] = we[i];
					wr_d[i] = d[i];
					if (!ref_mem.exists(key)) begin
						ref_mem[key] = '0;
					end
					if (we[i][0]) ref_mem[key][7:0] = d[i][7:0];
					if (we[i][1]) ref_mem[key][15:8] = d[i][15:8];
				end
				rd_prev[i] = rd[i];
				we_prev[i] = |we[i];
			end
			start_prev = start_now;
			rdy_prev = fb_rdy;
		end

		if (row_end) begin
			$display("row %0d: %s", row_idx, (err_cnt == row_err_base) ? "ok" : "mismatch");
			row_err_base = err_cnt;
		end
	end

endmodule

`default_nettype wire

// File: dv/tb_fb_split.sv
//////////////////////////////
// Testbench for the split framebuffer.
// Rows are applied on the falling edge, one at a time.
// External memory answers with a random busy time.
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module tb_fb_split;
	import fb_split_pkg::*;

	localparam int unsigned SEED = 32'h77941f29;
	localparam int TIMEOUT = 200;

	typedef struct {
		logic [1:0] mask;
		logic       op;
		int         col;
		int         line;
		pix_t       data;
		be_t        be;
	} row_t;

	logic      clk_sys;
	logic      rst_sys;
	fb_addr_t  fb0_addr, fb1_addr;
	pix_t      fb0_d, fb1_d, fb0_q, fb1_q;
	be_t       fb0_we, fb1_we;
	logic      fb0_rd, fb1_rd;
	logic      fb_rdy;
	ext_addr_t ext_addr;
	pix_t      ext_d, ext_q;
	be_t       ext_we;
	logic      ext_rd, ext_busy;
	logic      row_end;
	logic [31:0] row_idx;
	int        err_cnt, chk_cnt;

	row_t      rows [$];
	pix_t      ext_mem [ext_addr_t];
	int        busy_cnt;
	int        pool_col [8] = '{5, 100, 200, 351, 352, 380, 420, 511};
	int        pool_line [8] = '{0, 17, 128, 255, 3, 64, 200, 255};

	fb_split_top fb_split_top_i (.*);

	fb_split_checker fb_split_checker_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Unwritten external words
	function automatic pix_t fill_word(input ext_addr_t a);
		return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a3c;
	endfunction

	//////////////////////////////
	// External memory model
	//////////////////////////////
	always @(negedge clk_sys) begin
		if (rst_sys) begin
			busy_cnt = 0;
			ext_busy = 1'b0;
		end else if (ext_rd) begin
			ext_q = ext_mem.exists(ext_addr) ? ext_mem[ext_addr] : fill_word(ext_addr);
			busy_cnt = 1 + $urandom % 6;
			ext_busy = 1'b1;
		end else if (|ext_we) begin
			if (!ext_mem.exists(ext_addr)) ext_mem[ext_addr] = fill_word(ext_addr);
			if (ext_we[0]) ext_mem[ext_addr][7:0] = ext_d[7:0];
			if (ext_we[1]) ext_mem[ext_addr][15:8] = ext_d[15:8];
			busy_cnt = 1 + $urandom % 6;
			ext_busy = 1'b1;
		end else if (busy_cnt > 0) begin
			busy_cnt--;
			ext_busy = (busy_cnt != 0);
		end
	end

	task automatic stop_on_timeout(input string what);
		$display("timeout: %s", what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	function automatic void add_row(input logic [1:0] mask, input logic op, input int col,
		input int line, input pix_t data, input be_t be);
		row_t r;
		r = '{mask, op, col, line, data, be};
		rows.push_back(r);
	endfunction

	// Called on a falling edge, returns on a falling edge
	task automatic apply_row(input row_t r, input int idx);
		fb_addr_t a;
		int cnt;
		a = {r.line[7:0], r.col[8:0]};
		if (r.mask[0]) begin
			fb0_addr = a;
			fb0_d = r.data;
			if (r.op) fb0_rd = 1'b1;
			else fb0_we = r.be;
		end
		if (r.mask[1]) begin
			fb1_addr = a;
			fb1_d = ~r.data;
			if (r.op) fb1_rd = 1'b1;
			else fb1_we = r.be;
		end
		cnt = 0;
		do begin
			@(negedge clk_sys);
			cnt++;
		end while (!fb_rdy && cnt < TIMEOUT);
		if (!fb_rdy) stop_on_timeout($sformatf("row %0d never saw fb_rdy", idx));
		fb0_rd = 1'b0;
		fb1_rd = 1'b0;
		fb0_we = '0;
		fb1_we = '0;
		@(negedge clk_sys);
		row_idx = idx;
		row_end = 1'b1;
		@(negedge clk_sys);
		row_end = 1'b0;
	endtask

	initial begin
		int p;
		void'($urandom(SEED));
		rst_sys = 1'b1;
		{fb0_addr, fb1_addr, fb0_d, fb1_d, fb0_we, fb1_we, fb0_rd, fb1_rd} = '0;
		ext_busy = 1'b0;
		ext_q = '0;
		row_end = 1'b0;
		row_idx = '0;

		// On-chip write, partial overwrite, read back
		add_row(2'b01, 1'b0, 10, 3, 16'h1234, 2'b11);
		add_row(2'b01, 1'b0, 10, 3, 16'habcd, 2'b01);
		add_row(2'b01, 1'b1, 10, 3, 16'h0000, 2'b00);
		add_row(2'b10, 1'b0, 351, 255, 16'h55aa, 2'b11);
		add_row(2'b10, 1'b1, 351, 255, 16'h0000, 2'b00);
		// External region on each buffer
		add_row(2'b01, 1'b0, 400, 7, 16'hc0de, 2'b11);
		add_row(2'b01, 1'b1, 400, 7, 16'h0000, 2'b00);
		add_row(2'b10, 1'b0, 352, 0, 16'h8421, 2'b11);
		add_row(2'b10, 1'b0, 352, 0, 16'hf00f, 2'b10);
		add_row(2'b10, 1'b1, 352, 0, 16'h0000, 2'b00);
		// Both buffers at once
		add_row(2'b11, 1'b0, 500, 9, 16'h3c3c, 2'b11);
		add_row(2'b11, 1'b1, 500, 9, 16'h0000, 2'b00);
		// Random sweep over a preloaded pool
		for (int i = 0; i < 8; i++) begin
			add_row(2'b11, 1'b0, pool_col[i], pool_line[i], pix_t'($urandom), 2'b11);
		end
		for (int i = 0; i < 40; i++) begin
			p = $urandom % 8;
			add_row(2'(1 + $urandom % 3), 1'($urandom), pool_col[p], pool_line[p],
				pix_t'($urandom), be_t'(1 + $urandom % 3));
		end

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_sys = 1'b0;
		@(negedge clk_sys);

		foreach (rows[i]) begin
			apply_row(rows[i], i);
		end
		repeat (2) @(negedge clk_sys);

		$display("rows %0d, checks %0d, errors %0d", rows.size(), chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/fb_split_pkg.sv
verilog/fb_local_ram.sv
verilog/fb_bank.sv
verilog/fb_ext_arbiter.sv
verilog/fb_split_top.sv
dv/fb_split_checker.sv
dv/tb_fb_split.sv
